/* hdl/ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "int_pipe_cfg.svh"

module ex_stage (
  input  wire                   clk,
  input  wire                   rst,
  id_ex_if.snk                  id_ex,
  wb_if.src                     wb,
  output logic                  redirect_valid,
  output int_pipe_pkg::xlen_t   redirect_pc,
  output int_pipe_pkg::xlen_t   wb_pc
);
  import int_pipe_pkg::*;

  logic   ex_valid;
  logic   retire;
  logic   taken;
  id_ex_t ex_r;
  xlen_t  alu_raw;
  xlen_t  alu_res;
  xlen_t  jalr_tgt;

  assign id_ex.allowin = !ex_valid || wb.ready;
  assign retire        = ex_valid && wb.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else if (id_ex.allowin) begin
      ex_valid <= id_ex.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (id_ex.valid && id_ex.allowin) begin
      ex_r <= id_ex.payload;
    end
  end

  // word ops shift by 5 bits and only see the low half
  wire [5:0]  shamt  = ex_r.is_word ? {1'b0, ex_r.op2[4:0]} : ex_r.op2[5:0];
  wire [31:0] op1_lo = ex_r.op1[31:0];

  always_comb begin
    case (ex_r.alu_op)
      alu_add:  alu_raw = ex_r.op1 + ex_r.op2;
      alu_sub:  alu_raw = ex_r.op1 - ex_r.op2;
      alu_slt:  alu_raw = xlen_t'($signed(ex_r.op1) < $signed(ex_r.op2));
      alu_sltu: alu_raw = xlen_t'(ex_r.op1 < ex_r.op2);
      alu_xor:  alu_raw = ex_r.op1 ^ ex_r.op2;
      alu_or:   alu_raw = ex_r.op1 | ex_r.op2;
      alu_and:  alu_raw = ex_r.op1 & ex_r.op2;
      alu_sll:  alu_raw = ex_r.op1 << shamt;
      alu_srl: begin
        alu_raw = ex_r.is_word ? xlen_t'(op1_lo >> shamt) : ex_r.op1 >> shamt;
      end
      alu_sra: begin
        alu_raw = ex_r.is_word ? xlen_t'($signed(op1_lo) >>> shamt)
                               : xlen_t'($signed(ex_r.op1) >>> shamt);
      end
      default:  alu_raw = '0;
    endcase
  end

  assign alu_res = ex_r.is_word ? {{(`XLEN-32){alu_raw[31]}}, alu_raw[31:0]} : alu_raw;

  // branch condition
  wire eq  = (ex_r.src1 == ex_r.src2);
  wire lt  = ($signed(ex_r.src1) < $signed(ex_r.src2));
  wire ltu = (ex_r.src1 < ex_r.src2);

  always_comb begin
    case (ex_r.bj_op)
      bj_beq:  taken = eq;
      bj_bne:  taken = !eq;
      bj_blt:  taken = lt;
      bj_bge:  taken = !lt;
      bj_bltu: taken = ltu;
      bj_bgeu: taken = !ltu;
      bj_jal,
      bj_jalr: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  assign jalr_tgt = ex_r.src1 + ex_r.jmp_imm;
  assign redirect_pc = (ex_r.bj_op == bj_jalr) ? {jalr_tgt[`XLEN-1:1], 1'b0}
                                               : ex_r.pc + ex_r.jmp_imm;
  // one pulse, only when the jump actually retires
  assign redirect_valid = retire && taken;

  // link value for jumps comes out of the adder as pc + 4
  assign wb.valid = ex_valid;
  assign wb.wen   = ex_r.rd_wen;
  assign wb.rd    = ex_r.rd;
  assign wb.data  = alu_res;
  assign wb_pc    = ex_r.pc;

endmodule

`default_nettype wire

/* hdl/id_stage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "int_pipe_cfg.svh"

module id_stage (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          inst_valid,
  input  wire int_pipe_pkg::inst_t     inst,
  input  wire int_pipe_pkg::xlen_t     pc,
  output logic                         inst_allowin,
  output int_pipe_pkg::reg_addr_t      rs1_addr,
  output int_pipe_pkg::reg_addr_t      rs2_addr,
  input  wire int_pipe_pkg::xlen_t     rs1_data,
  input  wire int_pipe_pkg::xlen_t     rs2_data,
  input  wire                          redirect_valid,
  wb_if.byp                            wb,
  id_ex_if.src                         id_ex
);
  import int_pipe_pkg::*;

  logic    id_valid;
  inst_t   inst_r;
  xlen_t   pc_r;
  inst_t   id_inst;
  xlen_t   src1;
  xlen_t   src2;
  xlen_t   imm_i;
  xlen_t   imm_b;
  xlen_t   imm_u;
  xlen_t   imm_j;
  alu_op_e alu_op;
  bj_op_e  bj_op;
  id_ex_t  pl;

  assign inst_allowin = !id_valid || id_ex.allowin;
  // flushed instruction never reaches execute
  assign id_ex.valid = id_valid && !redirect_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      id_valid <= 1'b0;
    end else if (redirect_valid) begin
      id_valid <= 1'b0;
    end else if (inst_allowin) begin
      id_valid <= inst_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (inst_valid && inst_allowin) begin
      inst_r <= inst;
      pc_r   <= pc;
    end
  end

  // empty stage decodes as a nop
  assign id_inst = id_valid ? inst_r : `NOP_INST;

  wire [6:0] opcode = id_inst[6:0];
  wire [2:0] funct3 = id_inst[14:12];

  wire op_imm     = (opcode == 7'h13);
  wire op_imm_w   = (opcode == 7'h1b);
  wire op_reg     = (opcode == 7'h33);
  wire op_reg_w   = (opcode == 7'h3b);
  wire op_lui     = (opcode == 7'h37);
  wire op_auipc   = (opcode == 7'h17);
  wire op_jal     = (opcode == 7'h6f);
  wire op_jalr    = (opcode == 7'h67);
  wire op_br      = (opcode == 7'h63);
  wire is_word    = op_imm_w || op_reg_w;
  wire word_f3_ok = (funct3 == 3'd0) || (funct3 == 3'd1) || (funct3 == 3'd5);
  wire arith      = op_imm || op_reg || (is_word && word_f3_ok);
  wire rd_write   = arith || op_lui || op_auipc || op_jal || op_jalr;

  assign rs1_addr = id_inst[19:15];
  assign rs2_addr = id_inst[24:20];

  assign imm_i = {{(`XLEN-12){id_inst[31]}}, id_inst[31:20]};
  assign imm_b = {{(`XLEN-13){id_inst[31]}}, id_inst[31], id_inst[7],
                  id_inst[30:25], id_inst[11:8], 1'b0};
  assign imm_u = {{(`XLEN-32){id_inst[31]}}, id_inst[31:12], 12'b0};
  assign imm_j = {{(`XLEN-21){id_inst[31]}}, id_inst[31], id_inst[19:12],
                  id_inst[20], id_inst[30:21], 1'b0};

  // bypass from the instruction in the retire slot
  assign src1 = (wb.valid && wb.wen && wb.rd == rs1_addr) ? wb.data : rs1_data;
  assign src2 = (wb.valid && wb.wen && wb.rd == rs2_addr) ? wb.data : rs2_data;

  always_comb begin
    alu_op = alu_add;
    if (arith) begin
      case (funct3)
        3'd0: alu_op = ((op_reg || op_reg_w) && id_inst[30]) ? alu_sub : alu_add;
        3'd1: alu_op = alu_sll;
        3'd2: alu_op = alu_slt;
        3'd3: alu_op = alu_sltu;
        3'd4: alu_op = alu_xor;
        3'd5: alu_op = id_inst[30] ? alu_sra : alu_srl;
        3'd6: alu_op = alu_or;
        default: alu_op = alu_and;
      endcase
    end
  end

  always_comb begin
    bj_op = bj_none;
    if (op_jal) begin
      bj_op = bj_jal;
    end else if (op_jalr) begin
      bj_op = bj_jalr;
    end else if (op_br) begin
      case (funct3)
        3'd0: bj_op = bj_beq;
        3'd1: bj_op = bj_bne;
        3'd4: bj_op = bj_blt;
        3'd5: bj_op = bj_bge;
        3'd6: bj_op = bj_bltu;
        3'd7: bj_op = bj_bgeu;
        default: bj_op = bj_none;
      endcase
    end
  end

  always_comb begin
    pl.pc      = pc_r;
    pl.src1    = src1;
    pl.src2    = src2;
    pl.alu_op  = alu_op;
    pl.bj_op   = bj_op;
    pl.is_word = is_word;
    pl.rd      = id_inst[11:7];
    pl.rd_wen  = rd_write && (id_inst[11:7] != '0);
    pl.jmp_imm = op_jal ? imm_j : (op_jalr ? imm_i : imm_b);
    if (op_lui) begin
      pl.op1 = '0;
      pl.op2 = imm_u;
    end else if (op_auipc) begin
      pl.op1 = pc_r;
      pl.op2 = imm_u;
    end else if (op_jal || op_jalr) begin
      // link value
      pl.op1 = pc_r;
      pl.op2 = xlen_t'(4);
    end else if (op_imm || op_imm_w) begin
      pl.op1 = src1;
      pl.op2 = imm_i;
    end else begin
      pl.op1 = src1;
      pl.op2 = src2;
    end
  end

  assign id_ex.payload = pl;

endmodule

`default_nettype wire

/* hdl/int_pipe.sv */
`timescale 1ns/1ps
`default_nettype none
`include "int_pipe_cfg.svh"

module int_pipe (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          inst_valid,
  input  wire [`INST_W-1:0]            inst,
  input  wire [`XLEN-1:0]              pc,
  output logic                         inst_allowin,
  output logic                         wb_valid,
  input  wire                          wb_ready,
  output logic [`XLEN-1:0]             wb_pc,
  output logic                         wb_wen,
  output logic [$clog2(`REG_NUM)-1:0]  wb_rd,
  output logic [`XLEN-1:0]             wb_data,
  output logic                         redirect_valid,
  output logic [`XLEN-1:0]             redirect_pc
);

  logic [$clog2(`REG_NUM)-1:0] rs1_addr;
  logic [$clog2(`REG_NUM)-1:0] rs2_addr;
  logic [`XLEN-1:0]            rs1_data;
  logic [`XLEN-1:0]            rs2_data;

  id_ex_if id_ex_bus ();
  wb_if    wb_bus ();

  assign wb_bus.ready = wb_ready;
  assign wb_valid     = wb_bus.valid;
  assign wb_wen       = wb_bus.wen;
  assign wb_rd        = wb_bus.rd;
  assign wb_data      = wb_bus.data;

  id_stage id_stage_i (
    .clk            (clk),
    .rst            (rst),
    .inst_valid     (inst_valid),
    .inst           (inst),
    .pc             (pc),
    .inst_allowin   (inst_allowin),
    .rs1_addr       (rs1_addr),
    .rs2_addr       (rs2_addr),
    .rs1_data       (rs1_data),
    .rs2_data       (rs2_data),
    .redirect_valid (redirect_valid),
    .wb             (wb_bus.byp),
    .id_ex          (id_ex_bus.src)
  );

  regfile regfile_i (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb_bus.rf)
  );

  ex_stage ex_stage_i (
    .clk            (clk),
    .rst            (rst),
    .id_ex          (id_ex_bus.snk),
    .wb             (wb_bus.src),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .wb_pc          (wb_pc)
  );

endmodule

`default_nettype wire

/* hdl/int_pipe_cfg.svh */
`ifndef INT_PIPE_CFG_SVH
`define INT_PIPE_CFG_SVH

`define XLEN     64
`define INST_W   32
`define REG_NUM  32

// addi x0, x0, 0
`define NOP_INST 32'h0000_0013

`endif

/* hdl/int_pipe_pkg.sv */
`default_nettype none
`include "int_pipe_cfg.svh"

package int_pipe_pkg;

  typedef logic [`XLEN-1:0]             xlen_t;
  typedef logic [`INST_W-1:0]           inst_t;
  typedef logic [$clog2(`REG_NUM)-1:0]  reg_addr_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_or,
    alu_and,
    alu_sll,
    alu_srl,
    alu_sra
  } alu_op_e;

  // branch and jump kinds resolved in execute
  typedef enum logic [3:0] {
    bj_none,
    bj_beq,
    bj_bne,
    bj_blt,
    bj_bge,
    bj_bltu,
    bj_bgeu,
    bj_jal,
    bj_jalr
  } bj_op_e;

  typedef struct packed {
    xlen_t     pc;
    xlen_t     op1;
    xlen_t     op2;
    xlen_t     src1;
    xlen_t     src2;
    xlen_t     jmp_imm;
    alu_op_e   alu_op;
    bj_op_e    bj_op;
    logic      is_word;
    reg_addr_t rd;
    logic      rd_wen;
  } id_ex_t;

endpackage

`default_nettype wire

/* hdl/pipe_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

// decode to execute, valid/allowin handshake
interface id_ex_if;
  import int_pipe_pkg::*;

  logic   valid;
  logic   allowin;
  id_ex_t payload;

  modport src (output valid, output payload, input allowin);
  modport snk (input valid, input payload, output allowin);
endinterface

// retire port of execute
interface wb_if;
  import int_pipe_pkg::*;

  logic      valid;
  logic      ready;
  logic      wen;
  reg_addr_t rd;
  xlen_t     data;

  modport src (output valid, output wen, output rd, output data, input ready);
  modport rf  (input valid, input ready, input wen, input rd, input data);
  // bypass only; a transfer into execute implies ready
  modport byp (input valid, input wen, input rd, input data);
endinterface

`default_nettype wire

/* hdl/regfile.sv */
`timescale 1ns/1ps
`default_nettype none
`include "int_pipe_cfg.svh"

module regfile (
  input  wire                              clk,
  input  wire                              rst,
  input  wire int_pipe_pkg::reg_addr_t     rs1_addr,
  input  wire int_pipe_pkg::reg_addr_t     rs2_addr,
  output int_pipe_pkg::xlen_t              rs1_data,
  output int_pipe_pkg::xlen_t              rs2_data,
  wb_if.rf                                 wb
);
  import int_pipe_pkg::*;

  xlen_t regs [`REG_NUM];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `REG_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && wb.ready && wb.wen) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // x0 is hardwired
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* int_pipe.f */
+incdir+hdl
hdl/int_pipe_pkg.sv
hdl/pipe_ifs.sv
hdl/id_stage.sv
hdl/regfile.sv
hdl/ex_stage.sv
hdl/int_pipe.sv
test/int_pipe_tb.sv

/* test/int_pipe_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module int_pipe_tb;
  import int_pipe_pkg::*;

  localparam int MAX_CYCLES = 4000;

  typedef struct packed {
    xlen_t     pc;
    logic      wen;
    reg_addr_t rd;
    xlen_t     data;
    logic      redir;
    xlen_t     tgt;
  } exp_t;

  logic      clk;
  logic      rst;
  logic      inst_valid;
  inst_t     inst;
  xlen_t     pc;
  logic      inst_allowin;
  logic      wb_valid;
  logic      wb_ready;
  xlen_t     wb_pc;
  logic      wb_wen;
  reg_addr_t wb_rd;
  xlen_t     wb_data;
  logic      redirect_valid;
  xlen_t     redirect_pc;

  exp_t        exp_q[$];
  exp_t        head;
  xlen_t       mregs [32];
  xlen_t       shadow [32];
  xlen_t       cur_pc;
  logic        rand_ready;
  logic        rand_now;
  logic [31:0] rnd;
  int          cycles;

  int_pipe dut_i (
    .clk            (clk),
    .rst            (rst),
    .inst_valid     (inst_valid),
    .inst           (inst),
    .pc             (pc),
    .inst_allowin   (inst_allowin),
    .wb_valid       (wb_valid),
    .wb_ready       (wb_ready),
    .wb_pc          (wb_pc),
    .wb_wen         (wb_wen),
    .wb_rd          (wb_rd),
    .wb_data        (wb_data),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles >= MAX_CYCLES) begin
        $display("run stopped after %0d cycles without finishing", cycles);
        $display("tests failed");
        $fatal(1);
      end
    end
  end

  // retire port back-pressure
  initial begin
    wb_ready = 1'b1;
    forever begin
      @(posedge clk);
      rand_now = rand_ready;
      #1;
      wb_ready = rand_now ? ($urandom % 2 == 1) : 1'b1;
    end
  end

  task automatic check_data(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  // retire observed at the negedge before the edge that completes it
  initial begin
    forever begin
      @(negedge clk);
      if (!rst) begin
        if (wb_valid && wb_ready) begin
          if (exp_q.size() == 0) begin
            $display("retire of pc %h at %0t was not expected", wb_pc, $time);
            $display("tests failed");
            $fatal(1);
          end else begin
            head = exp_q.pop_front();
            check_data("wb_pc", wb_pc, head.pc);
            check_bit("wb_wen", wb_wen, head.wen);
            if (head.wen) begin
              check_reg("wb_rd", wb_rd, head.rd);
              check_data("wb_data", wb_data, head.data);
              shadow[wb_rd] = wb_data;
            end
            check_bit("redirect_valid", redirect_valid, head.redir);
            if (head.redir) begin
              check_data("redirect_pc", redirect_pc, head.tgt);
            end
          end
        end else begin
          check_bit("redirect_valid", redirect_valid, 1'b0);
        end
      end
    end
  end

  function automatic inst_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] f3,
                                   input reg_addr_t rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic inst_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                   input logic [2:0] f3, input reg_addr_t rd,
                                   input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic inst_t u_type(input logic [19:0] imm, input reg_addr_t rd,
                                   input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic inst_t b_type(input logic [12:0] off, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
  endfunction

  function automatic inst_t j_type(input logic [20:0] off, input reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
  endfunction

  function automatic xlen_t alu_model(input logic [2:0] f3, input logic alt,
                                      input logic word, input xlen_t x, input xlen_t y);
    logic [31:0] w;
    xlen_t       r;
    if (word) begin
      case (f3)
        3'd0: w = alt ? x[31:0] - y[31:0] : x[31:0] + y[31:0];
        3'd1: w = x[31:0] << y[4:0];
        default: begin
          if (alt) w = $signed(x[31:0]) >>> y[4:0];
          else w = x[31:0] >> y[4:0];
        end
      endcase
      r = {{32{w[31]}}, w};
    end else begin
      case (f3)
        3'd0: r = alt ? x - y : x + y;
        3'd1: r = x << y[5:0];
        3'd2: r = ($signed(x) < $signed(y)) ? 64'd1 : 64'd0;
        3'd3: r = (x < y) ? 64'd1 : 64'd0;
        3'd4: r = x ^ y;
        3'd5: begin
          if (alt) r = $signed(x) >>> y[5:0];
          else r = x >> y[5:0];
        end
        3'd6: r = x | y;
        default: r = x & y;
      endcase
    end
    return r;
  endfunction

  // ISA reference model that updates its registers at issue
  task automatic predict(input inst_t ins, input xlen_t at_pc, output exp_t e);
    logic [6:0] op;
    logic [2:0] f3;
    logic       alt;
    xlen_t      a;
    xlen_t      b;
    xlen_t      imm_i;
    xlen_t      imm_b;
    xlen_t      imm_u;
    xlen_t      imm_j;
    op    = ins[6:0];
    f3    = ins[14:12];
    a     = mregs[ins[19:15]];
    b     = mregs[ins[24:20]];
    imm_i = {{52{ins[31]}}, ins[31:20]};
    imm_b = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_u = {{32{ins[31]}}, ins[31:12], 12'b0};
    imm_j = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    alt   = ins[30] && (op == 7'h33 || op == 7'h3b || f3 == 3'd5);
    e     = '0;
    e.pc  = at_pc;
    e.rd  = ins[11:7];
    case (op)
      7'h13, 7'h33: begin
        e.data = alu_model(f3, alt, 1'b0, a, (op == 7'h13) ? imm_i : b);
        e.wen  = 1'b1;
      end
      7'h1b, 7'h3b: begin
        if (f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5) begin
          e.data = alu_model(f3, alt, 1'b1, a, (op == 7'h1b) ? imm_i : b);
          e.wen  = 1'b1;
        end
      end
      7'h37: begin
        e.data = imm_u;
        e.wen  = 1'b1;
      end
      7'h17: begin
        e.data = at_pc + imm_u;
        e.wen  = 1'b1;
      end
      7'h6f, 7'h67: begin
        e.data  = at_pc + 64'd4;
        e.wen   = 1'b1;
        e.redir = 1'b1;
        e.tgt   = (op == 7'h6f) ? at_pc + imm_j : (a + imm_i) & ~64'd1;
      end
      7'h63: begin
        case (f3)
          3'd0: e.redir = (a == b);
          3'd1: e.redir = (a != b);
          3'd4: e.redir = ($signed(a) < $signed(b));
          3'd5: e.redir = ($signed(a) >= $signed(b));
          3'd6: e.redir = (a < b);
          3'd7: e.redir = (a >= b);
          default: e.redir = 1'b0;
        endcase
        e.tgt = at_pc + imm_b;
      end
      default: e.wen = 1'b0;
    endcase
    if (e.rd == 5'd0) e.wen = 1'b0;
    if (e.wen) mregs[e.rd] = e.data;
  endtask

  // hold valid until the handshake completes
  task automatic send(input inst_t ins, input xlen_t at_pc);
    inst_valid = 1'b1;
    inst       = ins;
    pc         = at_pc;
    @(negedge clk);
    while (!inst_allowin) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    inst_valid = 1'b0;
  endtask

  task automatic wait_idle();
    do begin
      @(posedge clk);
    end while (exp_q.size() != 0);
    #1;
  endtask

  task automatic issue(input inst_t ins);
    exp_t e;
    predict(ins, cur_pc, e);
    exp_q.push_back(e);
    send(ins, cur_pc);
    if (e.redir) begin
      // wrong-path fetch that decode must flush
      send(i_type(12'h7ff, 5'd9, 3'd0, 5'd9, 7'h13), cur_pc + 64'd4);
      wait_idle();
      cur_pc = e.tgt;
    end else begin
      cur_pc = cur_pc + 64'd4;
    end
  endtask

  // register file contents against the retired writes
  task automatic compare_regs();
    for (int i = 0; i < 32; i++) begin
      check_data($sformatf("x%0d", i), dut_i.regfile_i.regs[i], shadow[i]);
    end
  endtask

  // every arithmetic form in a chain through the previous result
  task automatic arith_chain();
    reg_addr_t   prev;
    reg_addr_t   nxt;
    logic [6:0]  opc;
    logic [11:0] imm;
    logic [5:0]  sh;
    int          n;
    prev = 5'd1;
    n    = 0;
    for (int k = 0; k < 4; k++) begin
      opc = (k == 0) ? 7'h33 : (k == 1) ? 7'h13 : (k == 2) ? 7'h3b : 7'h1b;
      for (int f = 0; f < 8; f++) begin
        for (int alt = 0; alt < 2; alt++) begin
          if ((k < 2 || f == 0 || f == 1 || f == 5) &&
              (alt == 0 || f == 5 || (f == 0 && k % 2 == 0))) begin
            nxt = (prev == 5'd1) ? 5'd2 : 5'd1;
            rnd = $urandom;
            sh  = rnd[5:0];
            if (k >= 2) sh[5] = 1'b0;
            imm = (f == 1 || f == 5) ? {1'b0, alt[0], 4'b0, sh} : rnd[19:8];
            if (k % 2 == 1) begin
              issue(i_type(imm, prev, f[2:0], nxt, opc));
            end else if (n % 2 == 0) begin
              issue(r_type({1'b0, alt[0], 5'b0}, 5'd5, prev, f[2:0], nxt, opc));
            end else begin
              issue(r_type({1'b0, alt[0], 5'b0}, prev, 5'd5, f[2:0], nxt, opc));
            end
            prev = nxt;
            n++;
          end
        end
      end
    end
  endtask

  task automatic reset_latency_test();
    xlen_t p;
    @(negedge clk);
    check_bit("inst_allowin", inst_allowin, 1'b1);
    check_bit("wb_valid", wb_valid, 1'b0);
    check_bit("redirect_valid", redirect_valid, 1'b0);
    @(posedge clk);
    #1;
    p = cur_pc;
    issue(i_type(12'h05a, 5'd0, 3'd0, 5'd1, 7'h13));
    @(negedge clk);
    check_bit("wb_valid", wb_valid, 1'b0);
    @(negedge clk);
    check_bit("wb_valid", wb_valid, 1'b1);
    check_data("wb_pc", wb_pc, p);
    wait_idle();
  endtask

  task automatic arith_test();
    rnd = $urandom;
    issue(u_type(rnd[19:0], 5'd5, 7'h37));
    issue(i_type(rnd[31:20], 5'd5, 3'd0, 5'd5, 7'h13));
    issue(i_type(12'h011, 5'd5, 3'd1, 5'd5, 7'h13));
    rnd = $urandom;
    issue(i_type(rnd[11:0], 5'd5, 3'd4, 5'd5, 7'h13));
    issue(i_type(rnd[23:12], 5'd0, 3'd0, 5'd1, 7'h13));
    arith_chain();
    arith_chain();
    wait_idle();
    compare_regs();
  endtask

  task automatic upper_jump_test();
    logic [20:0] off;
    rnd = $urandom;
    issue(u_type(rnd[19:0], 5'd3, 7'h37));
    rnd = $urandom;
    issue(u_type(rnd[19:0], 5'd4, 7'h17));
    rnd = $urandom;
    off = {rnd[20:1], 1'b0};
    issue(j_type(off, 5'd1));
    rnd = $urandom;
    off = {rnd[20:1], 1'b0};
    issue(j_type(off, 5'd0));
    issue(i_type(12'h400, 5'd0, 3'd0, 5'd7, 7'h13));
    // odd sum so bit 0 of the target is dropped
    issue(i_type(12'h021, 5'd7, 3'd0, 5'd6, 7'h67));
    rnd = $urandom;
    issue(i_type(rnd[11:0], 5'd3, 3'd0, 5'd8, 7'h67));
    issue(i_type(12'h001, 5'd8, 3'd0, 5'd8, 7'h13));
    wait_idle();
    compare_regs();
  endtask

  task automatic branch_test();
    logic [12:0] off;
    reg_addr_t   ra;
    reg_addr_t   rb;
    issue(i_type(12'hffb, 5'd0, 3'd0, 5'd10, 7'h13));
    issue(i_type(12'h003, 5'd0, 3'd0, 5'd11, 7'h13));
    issue(i_type(12'h003, 5'd0, 3'd0, 5'd12, 7'h13));
    for (int f = 0; f < 8; f++) begin
      if (f != 2 && f != 3) begin
        // operand pairs cover taken and not taken for every condition
        for (int p = 0; p < 3; p++) begin
          ra  = (p == 0) ? 5'd10 : 5'd11;
          rb  = (p == 0) ? 5'd11 : (p == 1) ? 5'd12 : 5'd10;
          rnd = $urandom;
          off = {rnd[12:1], 1'b0};
          issue(b_type(off, rb, ra, f[2:0]));
          issue(i_type(12'h001, 5'd13, 3'd0, 5'd13, 7'h13));
        end
      end
    end
    wait_idle();
    compare_regs();
  endtask

  task automatic backpressure_test();
    rand_ready = 1'b1;
    arith_chain();
    arith_chain();
    wait_idle();
    rand_ready = 1'b0;
    compare_regs();
  endtask

  task automatic x0_unknown_test();
    issue(i_type(12'h007, 5'd5, 3'd0, 5'd0, 7'h13));
    issue(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd14, 7'h33));
    // opcode 7f is not decoded
    issue(32'hdead_beff);
    issue(i_type(12'h000, 5'd5, 3'd2, 5'd9, 7'h1b));
    issue(i_type(12'h055, 5'd0, 3'd0, 5'd15, 7'h13));
    wait_idle();
    compare_regs();
  endtask

  initial begin
    rnd        = $urandom(32'hf6a7_77cd);
    rst        = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    pc         = '0;
    rand_ready = 1'b0;
    cur_pc     = 64'h0000_0000_8000_0000;
    for (int i = 0; i < 32; i++) begin
      mregs[i]  = '0;
      shadow[i] = '0;
    end
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    reset_latency_test();
    arith_test();
    upper_jump_test();
    branch_test();
    backpressure_test();
    x0_unknown_test();
    wait_idle();
    // nothing may be left behind the last expected retire
    @(negedge clk);
    if (wb_valid) begin
      $display("an instruction is still in the pipeline after the last expected retire");
      $display("tests failed");
      $fatal(1);
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

`default_nettype wire
